// ==== tb/ara_stimulus.txt ====
// test op vd vs1 vs2 scalar expected, all fields in hex
// op 0 vadd, 1 vsub, 2 vand, 3 vxor, 4 vmv.v.x, 5 vext.x.s, 6 vcpop, 7 vsetvl
1 4 1 0 0 1234 0000
1 5 0 0 1 0000 1234
1 5 0 0 1 0001 1234
1 5 0 0 1 0002 1234
1 5 0 0 1 0003 1234
1 5 0 0 1 0004 1234
1 5 0 0 1 0005 1234
1 5 0 0 1 0006 1234
1 5 0 0 1 0007 1234
2 4 2 0 0 fff0 0000
2 4 3 0 0 0025 0000
2 0 4 3 2 0000 0000
2 5 0 0 4 0003 0015
2 1 5 2 3 0000 0000
2 5 0 0 5 0006 0035
2 2 6 3 2 0000 0000
2 5 0 0 6 0001 0020
2 3 7 3 2 0000 0000
2 5 0 0 7 000f ffd5
3 7 0 0 0 0005 0005
3 7 0 0 0 0014 0008
4 7 0 0 0 0005 0005
4 0 1 3 1 0000 0000
4 5 0 0 1 0000 1259
4 5 0 0 1 0004 1259
4 5 0 0 1 0005 1234
4 5 0 0 1 0006 1234
4 5 0 0 1 0007 1234
5 6 0 0 1 0000 0005
5 7 0 0 0 0008 0008
5 6 0 0 1 0000 0005
5 7 0 0 0 0003 0003
5 6 0 0 1 0000 0003
5 6 0 0 2 0000 0000
5 7 0 0 0 0007 0007
5 6 0 0 3 0000 0007
5 7 0 0 0 0000 0000
5 6 0 0 1 0000 0000

// ==== flist.f ====
common/ara_cfg_pkg.sv
common/ara_insn_pkg.sv
hw/dispatcher.sv
hw/sequencer.sv
lane/lane.sv
hw/mask_unit.sv
hw/ara_top.sv
tb/ara_sva.sv
tb/tb_ara.sv

// ==== Makefile ====
# Verilator build and run of the vector coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_ara
RTL_TOP   ?= ara_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_ara.sv ====
`timescale 1ns/1ps

module tb_ara;

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  localparam int CYCLES_PER_LINE = 64;
  localparam int RESET_CYCLES    = 4;

  // One stimulus line with its expected response
  typedef struct packed {
    logic [7:0]        test;
    core_req_t         req;
    logic [ELEM_W-1:0] exp_result;
  } stim_t;

  logic       clk;
  logic       rst;
  core_req_t  req;
  logic       req_valid;
  logic       req_ready;
  core_resp_t resp;
  logic       resp_valid;
  logic       resp_ready;
  logic       stall_en;
  integer     seed;
  int         cycle_cnt;
  int         timeout_limit;
  int         pass_cnt;
  int         error_cnt;
  int         assert_fails;
  stim_t      stim_q[$];

  ara_top ara_top_inst (
    .clk_i            (clk),
    .rst_i            (rst),
    .acc_req_i        (req),
    .acc_req_valid_i  (req_valid),
    .acc_req_ready_o  (req_ready),
    .acc_resp_o       (resp),
    .acc_resp_valid_o (resp_valid),
    .acc_resp_ready_i (resp_ready)
  );

  always #2 clk = ~clk;

  // Random stalls on the response channel in the second pass
  always @(posedge clk) begin
    if (stall_en) begin
      resp_ready <= (($random(seed) & 32'h3) != 0);
    end else begin
      resp_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((timeout_limit > 0) && (cycle_cnt >= timeout_limit)) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [ELEM_W-1:0] actual,
                             input logic [ELEM_W-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s returned %h, expected %h", $time, what, actual, expected);
      error_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    f[7];
    string line;
    stim_t entry;
    fd = $fopen("tb/ara_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/ara_stimulus.txt");
      error_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
      // Comment and blank lines do not scan
      if (n == 7) begin
        entry.test        = f[0][7:0];
        entry.req.op      = vop_e'(f[1][2:0]);
        entry.req.vd      = f[2][REG_W-1:0];
        entry.req.vs1     = f[3][REG_W-1:0];
        entry.req.vs2     = f[4][REG_W-1:0];
        entry.req.scalar  = f[5][ELEM_W-1:0];
        entry.exp_result  = f[6][ELEM_W-1:0];
        stim_q.push_back(entry);
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      $display("The stimulus file holds no instructions");
      error_cnt++;
    end
  endtask

  // Reset seen by the DUT on RESET_CYCLES rising edges
  task automatic apply_reset();
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Request accepted on the edge after a negedge with ready high
  task automatic send_instruction(input core_req_t r, output logic [ELEM_W-1:0] result);
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    while (!(resp_valid && resp_ready)) begin
      @(negedge clk);
    end
    result = resp.result;
  endtask

  task automatic run_pass(input int pass_no);
    logic [ELEM_W-1:0] result;
    vop_e              op;
    int                test_checks;
    int                err_base;
    test_checks = 0;
    err_base    = error_cnt;
    for (int i = 0; i < stim_q.size(); i++) begin
      op = stim_q[i].req.op;
      send_instruction(stim_q[i].req, result);
      check_value(result, stim_q[i].exp_result,
                  $sformatf("test %0d line %0d %s", stim_q[i].test, i, op.name()));
      test_checks++;
      if ((i == stim_q.size() - 1) || (stim_q[i + 1].test != stim_q[i].test)) begin
        $display("Pass %0d test %0d done: %0d checks, %0d errors",
                 pass_no, stim_q[i].test, test_checks, error_cnt - err_base);
        test_checks = 0;
        err_base    = error_cnt;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    req           = '0;
    req_valid     = 1'b0;
    resp_ready    = 1'b1;
    stall_en      = 1'b0;
    seed          = 32'h383be9e7;
    cycle_cnt     = 0;
    timeout_limit = 0;
    pass_cnt      = 0;
    error_cnt     = 0;
    assert_fails  = 0;
    load_stimulus();
    timeout_limit = 2 * stim_q.size() * CYCLES_PER_LINE + 4 * RESET_CYCLES;
    apply_reset();
    run_pass(1);
    // Same program again from reset, now with stalls
    stall_en = 1'b1;
    @(posedge clk);
    apply_reset();
    run_pass(2);
    assert_fails = ara_top_inst.ara_sva_inst.fail_cnt;
    $display("Checks passed: %0d, errors: %0d, assertion failures: %0d",
             pass_cnt, error_cnt, assert_fails);
    if ((error_cnt == 0) && (assert_fails == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/ara_sva.sv ====
`timescale 1ns/1ps

module ara_sva (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic                     req_valid_i,
  input logic                     req_ready_i,
  input ara_insn_pkg::core_resp_t resp_i,
  input logic                     resp_valid_i,
  input logic                     resp_ready_i
);

  int   fail_cnt = 0;
  logic pending_q;

  // Set from acceptance until the response is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      pending_q <= 1'b1;
    end else if (resp_valid_i && resp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // Response held while the core stalls
  resp_stable_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_i))
  ) else begin
    fail_cnt++;
    $error("response changed before it was taken");
  end

  // Core held off until the pending response is taken
  no_accept_pending_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    pending_q |-> !req_ready_i
  ) else begin
    fail_cnt++;
    $error("request could be accepted while a response was pending");
  end

  resp_idle_after_reset_a: assert property (
    @(posedge clk_i) rst_i |=> !resp_valid_i
  ) else begin
    fail_cnt++;
    $error("response valid right after reset");
  end

endmodule

bind ara_top ara_sva ara_sva_inst (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_valid_i  (acc_req_valid_i),
  .req_ready_i  (acc_req_ready_o),
  .resp_i       (acc_resp_o),
  .resp_valid_i (acc_resp_valid_o),
  .resp_ready_i (acc_resp_ready_i)
);

// ==== hw/ara_top.sv ====
`timescale 1ns/1ps

module ara_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ara_insn_pkg::core_req_t  acc_req_i,
  input  logic                     acc_req_valid_i,
  output logic                     acc_req_ready_o,
  output ara_insn_pkg::core_resp_t acc_resp_o,
  output logic                     acc_resp_valid_o,
  input  logic                     acc_resp_ready_i
);

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////////////////////////

  pe_req_t           disp_req;
  logic              issue;
  logic              seq_done;
  logic [ELEM_W-1:0] seq_scalar;

  dispatcher dispatcher_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .pe_req_o         (disp_req),
    .issue_o          (issue),
    .seq_done_i       (seq_done),
    .seq_scalar_i     (seq_scalar)
  );

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  pe_req_t                      pe_req;
  logic          [NR_PES-1:0]   pe_start;
  logic          [NR_PES-1:0]   pe_done;
  lane_operand_t [NR_LANES-1:0] lane_operand;
  logic          [ELEM_W-1:0]   mask_result;

  sequencer sequencer_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .pe_req_i       (disp_req),
    .issue_i        (issue),
    .seq_done_o     (seq_done),
    .seq_scalar_o   (seq_scalar),
    .pe_req_o       (pe_req),
    .pe_start_o     (pe_start),
    .pe_done_i      (pe_done),
    .lane_operand_i (lane_operand),
    .mask_result_i  (mask_result)
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes and mask unit
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    lane #(
      .LANE_ID (l)
    ) lane_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .pe_req_i  (pe_req),
      .start_i   (pe_start[l]),
      .done_o    (pe_done[l]),
      .operand_o (lane_operand[l])
    );
  end

  // Mask unit sits on the last PE slot
  mask_unit mask_unit_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (pe_start[NR_PES-1]),
    .lane_operand_i (lane_operand),
    .done_o         (pe_done[NR_PES-1]),
    .result_o       (mask_result)
  );

endmodule

// ==== hw/mask_unit.sv ====
`timescale 1ns/1ps

module mask_unit (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  logic                                                   start_i,
  input  ara_insn_pkg::lane_operand_t [ara_cfg_pkg::NR_LANES-1:0] lane_operand_i,
  output logic                                                   done_o,
  output logic [ara_cfg_pkg::ELEM_W-1:0]                         result_o
);

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  typedef enum logic {
    IDLE,
    COUNT
  } state_e;

  state_e              state_q;
  logic [NR_LANES-1:0] last_q;
  logic [NR_LANES-1:0] last_now;
  logic [ELEM_W-1:0]   cnt_q;
  logic [ELEM_W-1:0]   beat_sum;

  // Active bits arriving this cycle from all lanes
  always_comb begin
    beat_sum = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      beat_sum    = beat_sum + ELEM_W'(lane_operand_i[l].valid & lane_operand_i[l].data[0]);
      last_now[l] = last_q[l] | lane_operand_i[l].last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counting
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      last_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            last_q  <= '0;
            state_q <= COUNT;
          end
        end
        COUNT: begin
          last_q <= last_now;
          if (&last_now) begin
            done_o  <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && start_i) begin
      cnt_q <= '0;
    end else if (state_q == COUNT) begin
      cnt_q    <= cnt_q + beat_sum;
      result_o <= cnt_q + beat_sum;
    end
  end

endmodule

// ==== lane/lane.sv ====
`timescale 1ns/1ps

module lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  ara_insn_pkg::pe_req_t       pe_req_i,
  input  logic                        start_i,
  output logic                        done_o,
  output ara_insn_pkg::lane_operand_t operand_o
);

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  // Register slice: slot s of a register holds element s*NR_LANES+LANE_ID
  logic [ELEM_W-1:0] vrf_q [NR_VREGS][SLOTS];

  state_e            state_q;
  pe_req_t           req_q;
  logic [SLOT_W-1:0] slot_q;
  logic [CNT_W-1:0]  remain_q;
  logic              empty_q;
  logic [CNT_W-1:0]  elem_cnt;
  logic [SLOT_W-1:0] first_slot;
  logic [IDX_W-1:0]  ext_idx;
  logic              streaming;
  logic [ELEM_W-1:0] opa;
  logic [ELEM_W-1:0] opb;
  logic [ELEM_W-1:0] alu_res;

  //////////////////////////////////////////////////////////////////////
  // Work out the active elements at start
  //////////////////////////////////////////////////////////////////////

  assign ext_idx = pe_req_i.scalar[IDX_W-1:0];

  always_comb begin
    if (pe_req_i.op == VEXT_XS) begin
      // Extract ignores vl, always a single element
      elem_cnt   = CNT_W'(1);
      first_slot = ext_idx[IDX_W-1:LANE_W];
    end else begin
      elem_cnt   = CNT_W'((int'(pe_req_i.vl) + NR_LANES - 1 - LANE_ID) / NR_LANES);
      first_slot = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Element ALU
  //////////////////////////////////////////////////////////////////////

  assign opa = vrf_q[req_q.vs2][slot_q];
  assign opb = vrf_q[req_q.vs1][slot_q];

  // vs2 op vs1, wrapping at ELEM_W
  always_comb begin
    case (req_q.op)
      VADD:    alu_res = opa + opb;
      VSUB:    alu_res = opa - opb;
      VAND:    alu_res = opa & opb;
      VXOR:    alu_res = opa ^ opb;
      VMV_VX:  alu_res = req_q.scalar;
      default: alu_res = opa;
    endcase
  end

  assign streaming = (state_q == RUN) && (req_q.op inside {VCPOP, VEXT_XS});

  assign operand_o.valid = streaming;
  assign operand_o.last  = (streaming && (remain_q == CNT_W'(1))) || empty_q;
  assign operand_o.data  = opa;

  //////////////////////////////////////////////////////////////////////
  // Slot walk and write-back
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      done_o  <= 1'b0;
      empty_q <= 1'b0;
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int s = 0; s < SLOTS; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else begin
      done_o  <= 1'b0;
      empty_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            if (elem_cnt == '0) begin
              // Nothing to do here, end the stream right away
              done_o  <= 1'b1;
              empty_q <= (pe_req_i.op inside {VCPOP, VEXT_XS});
            end else begin
              state_q <= RUN;
            end
          end
        end
        RUN: begin
          if (!(req_q.op inside {VCPOP, VEXT_XS})) begin
            vrf_q[req_q.vd][slot_q] <= alu_res;
          end
          if (remain_q == CNT_W'(1)) begin
            done_o  <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && start_i) begin
      req_q    <= pe_req_i;
      slot_q   <= first_slot;
      remain_q <= elem_cnt;
    end else if (state_q == RUN) begin
      slot_q   <= slot_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

endmodule

// ==== hw/sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  ara_insn_pkg::pe_req_t                                  pe_req_i,
  input  logic                                                   issue_i,
  output logic                                                   seq_done_o,
  output logic [ara_cfg_pkg::ELEM_W-1:0]                         seq_scalar_o,
  output ara_insn_pkg::pe_req_t                                  pe_req_o,
  output logic [ara_cfg_pkg::NR_PES-1:0]                         pe_start_o,
  input  logic [ara_cfg_pkg::NR_PES-1:0]                         pe_done_i,
  input  ara_insn_pkg::lane_operand_t [ara_cfg_pkg::NR_LANES-1:0] lane_operand_i,
  input  logic [ara_cfg_pkg::ELEM_W-1:0]                         mask_result_i
);

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e              state_q;
  logic [NR_PES-1:0]   pending_q;
  logic [NR_PES-1:0]   pending_next;
  logic [NR_PES-1:0]   start_mask;
  logic [LANE_W-1:0]   owner;
  logic [LANE_W-1:0]   owner_q;

  // Lane that holds element (scalar mod VLMAX)
  assign owner = pe_req_i.scalar[LANE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Units taking part
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    start_mask = '0;
    case (pe_req_i.op)
      VEXT_XS: start_mask[owner] = 1'b1;
      VCPOP: begin
        start_mask[NR_LANES-1:0] = '1;
        start_mask[NR_PES-1]     = 1'b1;
      end
      default: start_mask[NR_LANES-1:0] = '1;
    endcase
  end

  assign pending_next = pending_q & ~pe_done_i;

  //////////////////////////////////////////////////////////////////////
  // Issue and completion
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      pending_q  <= '0;
      pe_start_o <= '0;
      seq_done_o <= 1'b0;
    end else begin
      pe_start_o <= '0;
      seq_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (issue_i) begin
            pe_start_o <= start_mask;
            pending_q  <= start_mask;
            state_q    <= WAIT;
          end
        end
        WAIT: begin
          pending_q <= pending_next;
          if (pending_next == '0) begin
            seq_done_o <= 1'b1;
            state_q    <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Broadcast request and scalar capture
  always_ff @(posedge clk_i) begin
    if (issue_i && (state_q == IDLE)) begin
      pe_req_o <= pe_req_i;
      owner_q  <= owner;
    end
    if (state_q == WAIT) begin
      if ((pe_req_o.op == VEXT_XS) && lane_operand_i[owner_q].valid) begin
        seq_scalar_o <= lane_operand_i[owner_q].data;
      end
      if (pe_done_i[NR_PES-1]) begin
        seq_scalar_o <= mask_result_i;
      end
    end
  end

endmodule

// ==== hw/dispatcher.sv ====
`timescale 1ns/1ps

module dispatcher (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  ara_insn_pkg::core_req_t          acc_req_i,
  input  logic                             acc_req_valid_i,
  output logic                             acc_req_ready_o,
  output ara_insn_pkg::core_resp_t         acc_resp_o,
  output logic                             acc_resp_valid_o,
  input  logic                             acc_resp_ready_i,
  output ara_insn_pkg::pe_req_t            pe_req_o,
  output logic                             issue_o,
  input  logic                             seq_done_i,
  input  logic [ara_cfg_pkg::ELEM_W-1:0]   seq_scalar_i
);

  import ara_cfg_pkg::*;
  import ara_insn_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RESPOND
  } state_e;

  state_e          state_q;
  logic [VL_W-1:0] vl_q;
  logic [VL_W-1:0] vl_new;
  logic            accept;

  assign acc_req_ready_o  = (state_q == IDLE);
  assign acc_resp_valid_o = (state_q == RESPOND);
  assign accept           = acc_req_valid_i && acc_req_ready_o;

  // Requested length clamped to VLMAX
  always_comb begin
    if (acc_req_i.scalar > ELEM_W'(VLMAX)) begin
      vl_new = VL_W'(VLMAX);
    end else begin
      vl_new = acc_req_i.scalar[VL_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      vl_q    <= VL_W'(VLMAX);
      issue_o <= 1'b0;
    end else begin
      issue_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            // VSETVL never leaves the dispatcher
            if (acc_req_i.op == VSETVL) begin
              vl_q    <= vl_new;
              state_q <= RESPOND;
            end else begin
              issue_o <= 1'b1;
              state_q <= BUSY;
            end
          end
        end
        BUSY: begin
          if (seq_done_i) begin
            state_q <= RESPOND;
          end
        end
        RESPOND: begin
          if (acc_resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request and response payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pe_req_o.op     <= acc_req_i.op;
      pe_req_o.vd     <= acc_req_i.vd;
      pe_req_o.vs1    <= acc_req_i.vs1;
      pe_req_o.vs2    <= acc_req_i.vs2;
      pe_req_o.scalar <= acc_req_i.scalar;
      pe_req_o.vl     <= vl_q;
      if (acc_req_i.op == VSETVL) begin
        acc_resp_o.result <= ELEM_W'(vl_new);
      end
    end
    if ((state_q == BUSY) && seq_done_i) begin
      // Only extract and popcount return a scalar
      if (pe_req_o.op inside {VEXT_XS, VCPOP}) begin
        acc_resp_o.result <= seq_scalar_i;
      end else begin
        acc_resp_o.result <= '0;
      end
    end
  end

endmodule

// ==== common/ara_insn_pkg.sv ====
package ara_insn_pkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VADD    = 3'd0,
    VSUB    = 3'd1,
    VAND    = 3'd2,
    VXOR    = 3'd3,
    VMV_VX  = 3'd4,
    VEXT_XS = 3'd5,
    VCPOP   = 3'd6,
    VSETVL  = 3'd7
  } vop_e;

  //////////////////////////////////////////////////////////////////////
  // Core interface
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vop_e                            op;
    logic [ara_cfg_pkg::REG_W-1:0]   vd;
    logic [ara_cfg_pkg::REG_W-1:0]   vs1;
    logic [ara_cfg_pkg::REG_W-1:0]   vs2;
    logic [ara_cfg_pkg::ELEM_W-1:0]  scalar;
  } core_req_t;

  typedef struct packed {
    logic [ara_cfg_pkg::ELEM_W-1:0] result;
  } core_resp_t;

  //////////////////////////////////////////////////////////////////////
  // Internal traffic
  //////////////////////////////////////////////////////////////////////

  // Request broadcast to the processing elements, carries the vl in force
  typedef struct packed {
    vop_e                            op;
    logic [ara_cfg_pkg::REG_W-1:0]   vd;
    logic [ara_cfg_pkg::REG_W-1:0]   vs1;
    logic [ara_cfg_pkg::REG_W-1:0]   vs2;
    logic [ara_cfg_pkg::ELEM_W-1:0]  scalar;
    logic [ara_cfg_pkg::VL_W-1:0]    vl;
  } pe_req_t;

  // last without valid marks the end of an empty stream
  typedef struct packed {
    logic                           valid;
    logic                           last;
    logic [ara_cfg_pkg::ELEM_W-1:0] data;
  } lane_operand_t;

endpackage

// ==== common/ara_cfg_pkg.sv ====
package ara_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Machine sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES = 2;
  localparam int unsigned ELEM_W   = 16;
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned REG_W    = 3;
  localparam int unsigned VLMAX    = 8;

  // Elements of one register held by each lane
  localparam int unsigned SLOTS = VLMAX / NR_LANES;

  // Holds vl values 0 to VLMAX
  localparam int unsigned VL_W = 4;

  // Lanes first, mask unit is the last PE
  localparam int unsigned NR_PES = NR_LANES + 1;

  //////////////////////////////////////////////////////////////////////
  // Derived index widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned SLOT_W = $clog2(SLOTS);
  localparam int unsigned CNT_W  = $clog2(SLOTS + 1);
  localparam int unsigned IDX_W  = $clog2(VLMAX);
  localparam int unsigned LANE_W = $clog2(NR_LANES);

endpackage
